// File: conv_3x3_multi.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_3x3_multi
	import conv_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic stride2,
	input logic in_valid,
	input lane_pixels_t in_pixels,
	input logic [`CONV_LANES-1:0] weight_valid,
	input weight_t [`CONV_LANES-1:0] weight_data,
	output logic [1:0] in_credit_cnt,
	output logic out_valid,
	output sum_t out_sum,
	input logic out_credit
);

	conv_step_if step ();

	lane_sums_t lane_sums;
	logic [`CONV_LANES-1:0] lane_valid;
	sum_t tree_sum;
	logic tree_valid;

	conv_window_ctrl u_ctrl (
		.clk      (clk),
		.reset    (reset),
		.stride2  (stride2),
		.in_valid (in_valid),
		.step     (step.ctrl)
	);

	////////////////////////////////////////
	// Channel lanes
	////////////////////////////////////////

	for (genvar g = 0; g < `CONV_LANES; g++) begin : lane_g
		conv_lane u_lane (
			.clk          (clk),
			.reset        (reset),
			.step         (step.lane),
			.pixel        (in_pixels[g]),
			.weight_valid (weight_valid[g]),
			.weight_data  (weight_data[g]),
			.lane_sum     (lane_sums[g]),
			.sum_valid    (lane_valid[g])
		);
	end

	// Lanes share one beat strobe so lane 0 speaks for all of them
	lane_add_tree u_tree (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (lane_valid[0]),
		.lane_sums (lane_sums),
		.sum       (tree_sum),
		.sum_valid (tree_valid)
	);

	conv_out_queue u_queue (
		.clk           (clk),
		.reset         (reset),
		.wr_valid      (tree_valid),
		.wr_sum        (tree_sum),
		.drop          (step.drop),
		.out_credit    (out_credit),
		.out_valid     (out_valid),
		.out_sum       (out_sum),
		.in_credit_cnt (in_credit_cnt)
	);

endmodule

// File: conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

////////////////////////////////////////
// Word widths
////////////////////////////////////////

// Pixel and weight width
`define CONV_DATA_WIDTH 16
// Accumulator and result width
`define CONV_SUM_WIDTH 32

////////////////////////////////////////
// Frame and kernel geometry
////////////////////////////////////////

`define CONV_IMAGE_WIDTH 8
`define CONV_IMAGE_HEIGHT 8
`define CONV_KERNEL 3

// Channel lanes, power of two for the adder tree
`define CONV_LANES 4

// Queue depth is also the upstream's starting credit pool
`define CONV_OUT_FIFO_DEPTH 16
// Sink buffer depth and starting output credits
`define CONV_SINK_CREDITS 8

`endif

// File: conv_lane.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_lane
	import conv_pkg::*;
(
	input logic clk,
	input logic reset,
	conv_step_if.lane step,
	input pixel_t pixel,
	input logic weight_valid,
	input weight_t weight_data,
	output sum_t lane_sum,
	output logic sum_valid
);

	localparam int K = `CONV_KERNEL;
	localparam int TAPS = K * K;
	localparam int W = `CONV_IMAGE_WIDTH;
	localparam int PTR_W = $clog2(W);
	localparam int IDX_W = $clog2(TAPS);

	// Row delays, entry 0 is one row back
	pixel_t line_buf [K-1][W];
	logic [PTR_W-1:0] ptr;
	// Older window columns, top row first
	pixel_t hist [K][K-1];
	pixel_t new_col [K];
	pixel_t view [K][K];
	weight_t weights [TAPS];
	logic [IDX_W-1:0] widx;
	sum_t prod [TAPS];
	logic prod_valid;
	sum_t prod_total;

	////////////////////////////////////////
	// Line buffers and shift window
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			ptr <= '0;
		else if (step.beat)
			ptr <= (ptr == PTR_W'(W - 1)) ? '0 : ptr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (step.beat) begin
			line_buf[0][ptr] <= pixel;
			for (int j = 1; j < K - 1; j++) begin
				line_buf[j][ptr] <= line_buf[j-1][ptr];
			end
			for (int k = 0; k < K; k++) begin
				for (int j = 0; j < K - 2; j++) begin
					hist[k][j] <= hist[k][j+1];
				end
				hist[k][K-2] <= new_col[k];
			end
		end
	end

	// Current window including the pixel arriving now
	always_comb begin
		new_col[K-1] = pixel;
		for (int j = 0; j < K - 1; j++) begin
			new_col[K-2-j] = line_buf[j][ptr];
		end
		for (int k = 0; k < K; k++) begin
			for (int j = 0; j < K - 1; j++) begin
				view[k][j] = hist[k][j];
			end
			view[k][K-1] = new_col[k];
		end
	end

	////////////////////////////////////////
	// Kernel weights
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (weight_valid)
			weights[widx] <= weight_data;
	end

	// Row-major load order, restarts at tap 0 on a new frame
	always_ff @(posedge clk) begin
		if (reset)
			widx <= '0;
		else if (weight_valid)
			widx <= (widx == IDX_W'(TAPS - 1)) ? '0 : widx + 1'b1;
		else if (step.frame_start)
			widx <= '0;
	end

	////////////////////////////////////////
	// Multiply-accumulate
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (step.emit) begin
			for (int k = 0; k < K; k++) begin
				for (int j = 0; j < K; j++) begin
					prod[k*K+j] <= sum_t'(view[k][j]) * sum_t'(weights[k*K+j]);
				end
			end
		end
	end

	always_comb begin
		prod_total = '0;
		for (int i = 0; i < TAPS; i++) begin
			prod_total = prod_total + prod[i];
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid)
			lane_sum <= prod_total;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			prod_valid <= step.emit;
			sum_valid <= prod_valid;
		end
	end

endmodule

// File: conv_out_queue.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_out_queue
	import conv_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wr_valid,
	input sum_t wr_sum,
	input logic drop,
	input logic out_credit,
	output logic out_valid,
	output sum_t out_sum,
	output logic [1:0] in_credit_cnt
);

	localparam int DEPTH = `CONV_OUT_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(`CONV_SINK_CREDITS + 1);

	sum_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic pop;

	// Send whenever a result waits and the sink has room
	assign pop = (count != '0) && (credits != '0);
	assign out_valid = pop;
	assign out_sum = mem[rd_ptr];

	// A popped result and a dropped beat may both return a credit
	assign in_credit_cnt = {1'b0, pop} + {1'b0, drop};

	////////////////////////////////////////
	// Result FIFO
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_valid)
			mem[wr_ptr] <= wr_sum;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(wr_valid) - CNT_W'(pop);
		end
	end

	// Output credits
	always_ff @(posedge clk) begin
		if (reset)
			credits <= CRD_W'(`CONV_SINK_CREDITS);
		else
			credits <= credits + CRD_W'(out_credit) - CRD_W'(pop);
	end

	// Upstream credit bound keeps a free slot for every result in flight
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> count != CNT_W'(DEPTH));

	// Sink never hands back more credits than its buffer holds
	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= CRD_W'(`CONV_SINK_CREDITS));

endmodule

// File: conv_pkg.sv
`include "conv_consts.svh"

package conv_pkg;

	////////////////////////////////////////
	// Data words
	////////////////////////////////////////

	// Input channel pixel
	typedef logic signed [`CONV_DATA_WIDTH-1:0] pixel_t;

	// Kernel tap
	typedef logic signed [`CONV_DATA_WIDTH-1:0] weight_t;

	// Products and sums wrap at this width
	typedef logic signed [`CONV_SUM_WIDTH-1:0] sum_t;

	// One entry per channel lane
	typedef pixel_t [`CONV_LANES-1:0] lane_pixels_t;
	typedef sum_t [`CONV_LANES-1:0] lane_sums_t;

	////////////////////////////////////////
	// Window tracking
	////////////////////////////////////////

	// Fill covers the rows that cannot finish a window yet
	typedef enum logic {
		PH_FILL,
		PH_STREAM
	} win_phase_e;

endpackage

// File: conv_step_if.sv
`timescale 1ns/1ns

// Per-beat window control shared by all lanes
interface conv_step_if;

	// Input beat accepted this cycle
	logic beat;

	// This beat closes a window that is kept
	logic emit;

	// First beat of a new frame
	logic frame_start;

	// Credit return for a beat that kept no window
	logic drop;

	modport ctrl (
		output beat,
		output emit,
		output frame_start,
		output drop
	);

	modport lane (
		input beat,
		input emit,
		input frame_start
	);

endinterface

// File: conv_window_ctrl.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_window_ctrl
	import conv_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic stride2,
	input logic in_valid,
	conv_step_if.ctrl step
);

	localparam int EDGE = `CONV_KERNEL - 1;
	localparam int COL_W = $clog2(`CONV_IMAGE_WIDTH);
	localparam int ROW_W = $clog2(`CONV_IMAGE_HEIGHT);
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(`CONV_IMAGE_WIDTH - 1);
	localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`CONV_IMAGE_HEIGHT - 1);

	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic [COL_W-1:0] col_off;
	logic [ROW_W-1:0] row_off;
	logic end_of_row;
	logic end_of_frame;
	logic keep;
	win_phase_e phase;

	assign end_of_row = (col == LAST_COL);
	assign end_of_frame = end_of_row && (row == LAST_ROW);

	// Window is named by its bottom-right pixel
	assign col_off = col - COL_W'(EDGE);
	assign row_off = row - ROW_W'(EDGE);
	assign keep = (row >= ROW_W'(EDGE)) && (col >= COL_W'(EDGE)) &&
		(!stride2 || (!row_off[0] && !col_off[0]));

	assign step.beat = in_valid;
	assign step.emit = in_valid && keep;
	assign step.frame_start = in_valid && (col == '0) && (row == '0);

	////////////////////////////////////////
	// Position counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (in_valid) begin
			if (end_of_row) begin
				col <= '0;
				row <= end_of_frame ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Moves to streaming once the first full window rows are buffered
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_FILL;
		end else if (in_valid && end_of_row) begin
			case (phase)
				PH_FILL: if (row == ROW_W'(EDGE - 1)) phase <= PH_STREAM;
				PH_STREAM: if (end_of_frame) phase <= PH_FILL;
				default: phase <= PH_FILL;
			endcase
		end
	end

	// Non-kept beats hand their credit back a cycle later
	always_ff @(posedge clk) begin
		if (reset)
			step.drop <= 1'b0;
		else
			step.drop <= in_valid && !keep;
	end

	a_emit_in_stream: assert property (@(posedge clk) disable iff (reset)
		step.emit |-> phase == PH_STREAM);

endmodule

// File: files.f
+incdir+.
conv_pkg.sv
conv_step_if.sv
conv_window_ctrl.sv
conv_lane.sv
lane_add_tree.sv
conv_out_queue.sv
conv_3x3_multi.sv
tb_conv_3x3_multi.sv

// File: lane_add_tree.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module lane_add_tree
	import conv_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input lane_sums_t lane_sums,
	output sum_t sum,
	output logic sum_valid
);

	localparam int LEVELS = $clog2(`CONV_LANES);

	// Level 0 is the lane inputs, each later level halves the width
	for (genvar l = 0; l <= LEVELS; l++) begin : lvl_g
		localparam int N = `CONV_LANES >> l;

		sum_t node [N];
		logic vld;

		if (l == 0) begin : leaf_g
			always_comb begin
				for (int i = 0; i < N; i++) begin
					node[i] = lane_sums[i];
				end
			end

			assign vld = in_valid;
		end else begin : add_g
			// Pair lane i with lane i plus half the width
			always_ff @(posedge clk) begin
				for (int i = 0; i < N; i++) begin
					node[i] <= lvl_g[l-1].node[i] + lvl_g[l-1].node[i+N];
				end
			end

			always_ff @(posedge clk) begin
				if (reset)
					vld <= 1'b0;
				else
					vld <= lvl_g[l-1].vld;
			end
		end
	end

	////////////////////////////////////////
	// Root of the tree
	////////////////////////////////////////

	assign sum = lvl_g[LEVELS].node[0];
	assign sum_valid = lvl_g[LEVELS].vld;

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_conv_3x3_multi -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "Build or simulation aborted"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qF '** FAIL **' sim.log && exit 1 || exit 0

// File: tb_conv_3x3_multi.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module tb_conv_3x3_multi
	import conv_pkg::*;
();

	localparam int W = `CONV_IMAGE_WIDTH;
	localparam int H = `CONV_IMAGE_HEIGHT;
	localparam int K = `CONV_KERNEL;
	localparam int LANES = `CONV_LANES;
	localparam int TAPS = K * K;
	localparam int DEPTH = `CONV_OUT_FIFO_DEPTH;
	localparam int SINK = `CONV_SINK_CREDITS;
	localparam int FRAMES = 3;
	localparam int LIMIT = 1000;

	logic clk = 1'b0;
	logic reset;
	logic stride2;
	logic in_valid;
	lane_pixels_t in_pixels;
	logic [LANES-1:0] weight_valid;
	weight_t [LANES-1:0] weight_data;
	logic [1:0] in_credit_cnt;
	logic out_valid;
	sum_t out_sum;
	logic out_credit = 1'b0;

	pixel_t frame_pix [FRAMES][LANES][H][W];
	weight_t kern [LANES][TAPS];
	sum_t exp_q [$];
	sum_t exp_sum;

	integer seed = 73;
	int errors = 0;
	int checked = 0;
	int sent = 0;
	int returned = 0;
	int words_got = 0;
	int granted = 0;
	int sink_avail = SINK;
	int hold_start = 0;
	logic hold = 1'b0;

	always #2 clk = ~clk;

	conv_3x3_multi UUT (
		.clk           (clk),
		.reset         (reset),
		.stride2       (stride2),
		.in_valid      (in_valid),
		.in_pixels     (in_pixels),
		.weight_valid  (weight_valid),
		.weight_data   (weight_data),
		.in_credit_cnt (in_credit_cnt),
		.out_valid     (out_valid),
		.out_sum       (out_sum),
		.out_credit    (out_credit)
	);

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic flag_error(input string msg);
		errors++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	task automatic finish_run();
		$display("Results checked: %0d, errors: %0d", checked, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		errors++;
		finish_run();
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Window named by its bottom-right pixel
	function automatic bit window_kept(input int r, input int c, input bit s2);
		return (r >= K - 1) && (c >= K - 1) &&
			(!s2 || (((r - K + 1) % 2 == 0) && ((c - K + 1) % 2 == 0)));
	endfunction

	function automatic sum_t window_sum(input int f, input int r, input int c);
		sum_t acc;
		acc = '0;
		for (int l = 0; l < LANES; l++)
			for (int k = 0; k < K; k++)
				for (int j = 0; j < K; j++)
					acc = acc + sum_t'(frame_pix[f][l][r-K+1+k][c-K+1+j]) *
						sum_t'(kern[l][k*K+j]);
		return acc;
	endfunction

	////////////////////////////////////////
	// Output monitor and sink
	////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset) begin
			returned = returned + int'(in_credit_cnt);
			assert (returned <= sent)
				else flag_error("more upstream credits returned than beats sent");
			if (out_valid) begin
				assert (sink_avail > 0)
					else flag_error("out_valid without an output credit");
				assert (!hold || (words_got - hold_start) < SINK)
					else flag_error("word sent past the sink credits while withheld");
				if (exp_q.size() == 0) begin
					flag_error("output word with no result expected");
				end else begin
					exp_sum = exp_q.pop_front();
					assert (out_sum == exp_sum)
						else flag_error($sformatf("out_sum %0d, expected %0d", out_sum, exp_sum));
					checked++;
				end
				words_got++;
			end
			sink_avail = sink_avail + int'(out_credit) - int'(out_valid);
		end
	end

	// One credit back per word, skipped now and then
	always @(posedge clk) begin
		if (reset) begin
			out_credit <= 1'b0;
		end else if (words_got > granted && !hold && ($random(seed) & 3) != 0) begin
			out_credit <= 1'b1;
			granted++;
		end else begin
			out_credit <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic load_weights();
		for (int t = 0; t < TAPS; t++) begin
			@(posedge clk);
			weight_valid <= '1;
			for (int l = 0; l < LANES; l++)
				weight_data[l] <= kern[l][t];
		end
		@(posedge clk);
		weight_valid <= '0;
	endtask

	// Raster order, one beat per upstream credit
	task automatic send_frame(input int f);
		int r;
		int c;
		int idle;
		r = 0;
		c = 0;
		idle = 0;
		while (r < H) begin
			@(posedge clk);
			if (sent - returned < DEPTH) begin
				in_valid <= 1'b1;
				for (int l = 0; l < LANES; l++)
					in_pixels[l] <= frame_pix[f][l][r][c];
				sent++;
				idle = 0;
				c = (c == W - 1) ? 0 : c + 1;
				r = (c == 0) ? r + 1 : r;
			end else begin
				in_valid <= 1'b0;
				idle++;
				if (idle > LIMIT)
					stop_on_timeout("no upstream credit came back");
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic release_after_stall();
		int cycles;
		cycles = 0;
		while (words_got - hold_start < SINK) begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT)
				stop_on_timeout("sink credits were never used up");
		end
		cycles = 0;
		while (sent - returned < DEPTH) begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT)
				stop_on_timeout("upstream never ran out of credits");
		end
		hold <= 1'b0;
	endtask

	task automatic run_frame(input int f, input bit s2, input bit with_hold);
		int want_count;
		int first_word;
		int cycles;
		want_count = s2 ? ((H - K + 2) / 2) * ((W - K + 2) / 2) : (H - K + 1) * (W - K + 1);
		for (int r = 0; r < H; r++)
			for (int c = 0; c < W; c++)
				if (window_kept(r, c, s2))
					exp_q.push_back(window_sum(f, r, c));
		first_word = words_got;
		@(posedge clk);
		stride2 <= s2;
		if (with_hold) begin
			cycles = 0;
			while (words_got != granted || sink_avail != SINK) begin
				@(posedge clk);
				cycles++;
				if (cycles > LIMIT)
					stop_on_timeout("output credits did not settle");
			end
			hold <= 1'b1;
			hold_start = words_got;
			fork
				send_frame(f);
				release_after_stall();
			join
		end else begin
			send_frame(f);
		end
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT)
				stop_on_timeout("frame results did not all arrive");
		end
		cycles = 0;
		while (returned != sent) begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT)
				stop_on_timeout("upstream credits were not all returned");
		end
		assert (words_got - first_word == want_count)
			else flag_error($sformatf("frame gave %0d results, expected %0d",
				words_got - first_word, want_count));
	endtask

	initial begin
		reset = 1'b1;
		stride2 = 1'b0;
		in_valid = 1'b0;
		in_pixels = '0;
		weight_valid = '0;
		weight_data = '0;
		for (int f = 0; f < FRAMES; f++)
			for (int l = 0; l < LANES; l++)
				for (int r = 0; r < H; r++)
					for (int c = 0; c < W; c++)
						frame_pix[f][l][r][c] = pixel_t'($random(seed));
		for (int l = 0; l < LANES; l++)
			for (int t = 0; t < TAPS; t++)
				kern[l][t] = weight_t'($random(seed));
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!out_valid && in_credit_cnt == 2'd0)
			else flag_error("outputs not idle after reset");
		load_weights();
		run_frame(0, 1'b0, 1'b0);
		run_frame(1, 1'b1, 1'b0);
		// Sink withholds credits for the whole of this frame's start
		run_frame(2, 1'b0, 1'b1);
		finish_run();
	end

endmodule
